//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := tb_lsu_backend
RTL_TOP    := lsu_backend
FILELIST   := lsu_backend.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F -x -- '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- data_sram.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module data_sram (
    input  logic                    clk,
    input  logic                    en,
    input  logic [3:0]              we,
    input  logic [`LSU_DMEM_AW-1:0] addr,
    input  lsu_pkg::word_t          wdata,
    output lsu_pkg::word_t          rdata
);

    import lsu_pkg::*;

    word_t mem [0:`LSU_DMEM_WORDS-1];
    word_t merged;

    // Old word with the enabled bytes replaced
    always_comb begin
        merged = mem[addr];
        for (int i = 0; i < `LSU_DMEM_LANES; i++) begin
            if (we[i]) begin
                merged[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < `LSU_DMEM_LANES; i++) begin
                if (we[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
            rdata <= merged;
        end
    end

endmodule

`default_nettype wire

//--- lsu_backend.f
+incdir+.
lsu_pkg.sv
pipe_reg.sv
mem_stage.sv
data_sram.sv
wb_stage.sv
lsu_backend.sv
tb_lsu_backend.sv

//--- lsu_backend.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_backend (
    input  logic              clk,
    input  logic              rst,
    input  logic              ex_valid,
    output logic              ex_ready,
    input  lsu_pkg::word_t    ex_pc,
    input  lsu_pkg::word_t    ex_result,
    input  lsu_pkg::word_t    ex_rkd_value,
    input  lsu_pkg::mem_op_t  ex_mem_op,
    input  logic              ex_res_from_mem,
    input  logic              ex_gr_we,
    input  logic              ex_mem_we,
    input  lsu_pkg::reg_idx_t ex_dest,
    input  logic              wb_ready,
    output logic              wb_valid,
    output logic              rf_we,
    output lsu_pkg::reg_idx_t rf_waddr,
    output lsu_pkg::word_t    rf_wdata,
    output lsu_pkg::word_t    wb_pc
);

    import lsu_pkg::*;

    localparam ex_mem_t EX_RESET = '{pc: `LSU_RESET_PC, default: '0};

    ex_mem_t               ex_in;
    ex_mem_t               ex_q;
    logic                  mem_valid;
    logic                  mem_ready;
    logic [3:0]            dmem_we;
    logic                  dmem_en;
    logic [`LSU_DMEM_AW-1:0] dmem_addr;
    word_t                 dmem_wdata;
    word_t                 dmem_rdata;
    word_t                 m_pc;
    word_t                 m_result;
    mem_op_t               m_mem_op;
    logic                  m_res_from_mem;
    logic                  m_gr_we;
    reg_idx_t              m_dest;

    assign ex_in.pc           = ex_pc;
    assign ex_in.result       = ex_result;
    assign ex_in.mem_op       = ex_mem_op;
    assign ex_in.res_from_mem = ex_res_from_mem;
    assign ex_in.gr_we        = ex_gr_we;
    assign ex_in.mem_we       = ex_mem_we;
    assign ex_in.dest         = ex_dest;
    assign ex_in.rkd_value    = ex_rkd_value;

    pipe_reg #(
        .payload_t   (ex_mem_t),
        .RESET_VALUE (EX_RESET)
    ) u_ex_mem (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ex_valid),
        .in_ready  (ex_ready),
        .in_data   (ex_in),
        .out_valid (mem_valid),
        .out_ready (mem_ready),
        .out_data  (ex_q)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .rst             (rst),
        .in_valid        (mem_valid),
        .in_ready        (mem_ready),
        .pc              (ex_q.pc),
        .result          (ex_q.result),
        .rkd_value       (ex_q.rkd_value),
        .mem_op          (ex_q.mem_op),
        .res_from_mem    (ex_q.res_from_mem),
        .gr_we           (ex_q.gr_we),
        .mem_we          (ex_q.mem_we),
        .dest            (ex_q.dest),
        .dmem_en         (dmem_en),
        .dmem_we         (dmem_we),
        .dmem_addr       (dmem_addr),
        .dmem_wdata      (dmem_wdata),
        .out_valid       (wb_valid),
        .out_ready       (wb_ready),
        .wb_pc           (m_pc),
        .wb_result       (m_result),
        .wb_mem_op       (m_mem_op),
        .wb_res_from_mem (m_res_from_mem),
        .wb_gr_we        (m_gr_we),
        .wb_dest         (m_dest)
    );

    data_sram u_dmem (
        .clk   (clk),
        .en    (dmem_en),
        .we    (dmem_we),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

    wb_stage u_wb_stage (
        .wb_valid     (wb_valid),
        .wb_ready     (wb_ready),
        .pc           (m_pc),
        .result       (m_result),
        .mem_op       (m_mem_op),
        .res_from_mem (m_res_from_mem),
        .gr_we        (m_gr_we),
        .dest         (m_dest),
        .dmem_rdata   (dmem_rdata),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .wb_pc        (wb_pc)
    );

endmodule

`default_nettype wire

//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [7:0]  mem_op_t;

    // One-hot opcode bit positions
    localparam int OP_LD_B  = 0;
    localparam int OP_LD_H  = 1;
    localparam int OP_LD_W  = 2;
    localparam int OP_LD_BU = 3;
    localparam int OP_LD_HU = 4;
    localparam int OP_ST_B  = 5;
    localparam int OP_ST_H  = 6;
    localparam int OP_ST_W  = 7;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        mem_op_t  mem_op;
        logic     res_from_mem;
        logic     gr_we;
        logic     mem_we;
        reg_idx_t dest;
        word_t    rkd_value;
    } ex_mem_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        mem_op_t  mem_op;
        logic     res_from_mem;
        logic     gr_we;
        reg_idx_t dest;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// PC value held by the pipeline registers out of reset
`define LSU_RESET_PC 32'h1c000000

// Data RAM geometry in 32-bit words
`define LSU_DMEM_WORDS 1024

// Word address width covering LSU_DMEM_WORDS
`define LSU_DMEM_AW 10

// Byte lanes per data word
`define LSU_DMEM_LANES 4

`endif

//--- mem_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module mem_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  lsu_pkg::word_t          pc,
    input  lsu_pkg::word_t          result,
    input  lsu_pkg::word_t          rkd_value,
    input  lsu_pkg::mem_op_t        mem_op,
    input  logic                    res_from_mem,
    input  logic                    gr_we,
    input  logic                    mem_we,
    input  lsu_pkg::reg_idx_t       dest,
    output logic                    dmem_en,
    output logic [3:0]              dmem_we,
    output logic [`LSU_DMEM_AW-1:0] dmem_addr,
    output lsu_pkg::word_t          dmem_wdata,
    output logic                    out_valid,
    input  logic                    out_ready,
    output lsu_pkg::word_t          wb_pc,
    output lsu_pkg::word_t          wb_result,
    output lsu_pkg::mem_op_t        wb_mem_op,
    output logic                    wb_res_from_mem,
    output logic                    wb_gr_we,
    output lsu_pkg::reg_idx_t       wb_dest
);

    import lsu_pkg::*;

    localparam mem_wb_t WB_RESET = '{pc: `LSU_RESET_PC, default: '0};

    logic       fire;
    logic [3:0] lane_mask;
    mem_wb_t    wb_in;
    mem_wb_t    wb_q;

    // RAM is touched only when the instruction moves into writeback
    assign fire = in_valid & in_ready;

    always_comb begin
        lane_mask  = 4'b0000;
        dmem_wdata = rkd_value;
        if (mem_op[OP_ST_B]) begin
            lane_mask  = 4'b0001 << result[1:0];
            dmem_wdata = {4{rkd_value[7:0]}};
        end else if (mem_op[OP_ST_H]) begin
            lane_mask  = result[1] ? 4'b1100 : 4'b0011;
            dmem_wdata = {2{rkd_value[15:0]}};
        end else if (mem_op[OP_ST_W]) begin
            lane_mask  = 4'b1111;
        end
    end

    assign dmem_en   = fire;
    assign dmem_we   = {4{fire & mem_we}} & lane_mask;
    assign dmem_addr = result[`LSU_DMEM_AW+1:2];

    assign wb_in.pc           = pc;
    assign wb_in.result       = result;
    assign wb_in.mem_op       = mem_op;
    assign wb_in.res_from_mem = res_from_mem;
    assign wb_in.gr_we        = gr_we;
    assign wb_in.dest         = dest;

    pipe_reg #(
        .payload_t   (mem_wb_t),
        .RESET_VALUE (WB_RESET)
    ) u_mem_wb (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (wb_in),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (wb_q)
    );

    assign wb_pc           = wb_q.pc;
    assign wb_result       = wb_q.result;
    assign wb_mem_op       = wb_q.mem_op;
    assign wb_res_from_mem = wb_q.res_from_mem;
    assign wb_gr_we        = wb_q.gr_we;
    assign wb_dest         = wb_q.dest;

endmodule

`default_nettype wire

//--- pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type      payload_t   = logic [31:0],
    parameter payload_t RESET_VALUE = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic in_fire;

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = ~out_valid | out_ready;
    assign in_fire  = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_data <= RESET_VALUE;
        end else if (in_fire) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- tb_lsu_backend.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module tb_lsu_backend;

    import lsu_pkg::*;

    localparam int STALL_FREE_LATENCY = 2;

    localparam mem_op_t M_ALU   = 8'h00;
    localparam mem_op_t M_LD_B  = mem_op_t'(1 << OP_LD_B);
    localparam mem_op_t M_LD_H  = mem_op_t'(1 << OP_LD_H);
    localparam mem_op_t M_LD_W  = mem_op_t'(1 << OP_LD_W);
    localparam mem_op_t M_LD_BU = mem_op_t'(1 << OP_LD_BU);
    localparam mem_op_t M_LD_HU = mem_op_t'(1 << OP_LD_HU);
    localparam mem_op_t M_ST_B  = mem_op_t'(1 << OP_ST_B);
    localparam mem_op_t M_ST_H  = mem_op_t'(1 << OP_ST_H);
    localparam mem_op_t M_ST_W  = mem_op_t'(1 << OP_ST_W);

    typedef struct packed {
        mem_op_t  op;
        word_t    result;
        word_t    rkd_value;
        reg_idx_t dest;
        logic     gr_we;
        logic     res_from_mem;
        word_t    exp_wdata;
    } row_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     ex_valid;
    logic     ex_ready;
    word_t    ex_pc;
    word_t    ex_result;
    word_t    ex_rkd_value;
    mem_op_t  ex_mem_op;
    logic     ex_res_from_mem;
    logic     ex_gr_we;
    logic     ex_mem_we;
    reg_idx_t ex_dest;
    logic     wb_ready = 1'b0;
    logic     wb_valid;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;
    word_t    wb_pc;

    row_t rows[$];
    int   wb_ptr = 0;
    int   cycle_count = 0;
    int   timeout_limit = 0;

    lsu_backend i_lsu_backend (
        .clk             (clk),
        .rst             (rst),
        .ex_valid        (ex_valid),
        .ex_ready        (ex_ready),
        .ex_pc           (ex_pc),
        .ex_result       (ex_result),
        .ex_rkd_value    (ex_rkd_value),
        .ex_mem_op       (ex_mem_op),
        .ex_res_from_mem (ex_res_from_mem),
        .ex_gr_we        (ex_gr_we),
        .ex_mem_we       (ex_mem_we),
        .ex_dest         (ex_dest),
        .wb_ready        (wb_ready),
        .wb_valid        (wb_valid),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .wb_pc           (wb_pc)
    );

    always #20 clk = ~clk;

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Each row gets its own PC so that retirement order is visible on wb_pc
    function automatic word_t pc_for_row(input int idx);
        return `LSU_RESET_PC + word_t'(4 * (idx + 1));
    endfunction

    task automatic add_row(input mem_op_t op, input word_t result, input word_t rkd,
                           input reg_idx_t dest, input logic gr_we, input logic rfm,
                           input word_t exp_wdata);
        rows.push_back(row_t'{op, result, rkd, dest, gr_we, rfm, exp_wdata});
    endtask

    // Columns are mem_op, result, rkd_value, dest, gr_we, res_from_mem and expected rf_wdata
    task automatic build_table();
        add_row(M_ALU,   32'h12345678, 32'h00000000, 5'd1,  1'b1, 1'b0, 32'h12345678);
        add_row(M_ALU,   32'hdeadbeef, 32'h00000000, 5'd2,  1'b1, 1'b0, 32'hdeadbeef);
        // Word, then halfword into lanes 2-3, then byte into lane 1
        add_row(M_ST_W,  32'h00000100, 32'h11223344, 5'd0,  1'b0, 1'b0, 32'h00000000);
        add_row(M_ST_H,  32'h00000102, 32'h0000aabb, 5'd0,  1'b0, 1'b0, 32'h00000000);
        add_row(M_ST_B,  32'h00000101, 32'h000000cc, 5'd0,  1'b0, 1'b0, 32'h00000000);
        add_row(M_LD_W,  32'h00000100, 32'h00000000, 5'd3,  1'b1, 1'b1, 32'haabbcc44);
        // Bytes 01 ff 80 7f from lane 0 upward
        add_row(M_ST_W,  32'h00000200, 32'h7f80ff01, 5'd0,  1'b0, 1'b0, 32'h00000000);
        add_row(M_LD_B,  32'h00000200, 32'h00000000, 5'd4,  1'b1, 1'b1, 32'h00000001);
        add_row(M_LD_B,  32'h00000201, 32'h00000000, 5'd5,  1'b1, 1'b1, 32'hffffffff);
        add_row(M_LD_B,  32'h00000202, 32'h00000000, 5'd6,  1'b1, 1'b1, 32'hffffff80);
        add_row(M_LD_B,  32'h00000203, 32'h00000000, 5'd7,  1'b1, 1'b1, 32'h0000007f);
        add_row(M_LD_BU, 32'h00000200, 32'h00000000, 5'd8,  1'b1, 1'b1, 32'h00000001);
        add_row(M_LD_BU, 32'h00000201, 32'h00000000, 5'd9,  1'b1, 1'b1, 32'h000000ff);
        add_row(M_LD_BU, 32'h00000202, 32'h00000000, 5'd10, 1'b1, 1'b1, 32'h00000080);
        add_row(M_LD_BU, 32'h00000203, 32'h00000000, 5'd11, 1'b1, 1'b1, 32'h0000007f);
        add_row(M_LD_H,  32'h00000200, 32'h00000000, 5'd12, 1'b1, 1'b1, 32'hffffff01);
        add_row(M_LD_H,  32'h00000202, 32'h00000000, 5'd13, 1'b1, 1'b1, 32'h00007f80);
        add_row(M_LD_HU, 32'h00000200, 32'h00000000, 5'd14, 1'b1, 1'b1, 32'h0000ff01);
        add_row(M_LD_HU, 32'h00000202, 32'h00000000, 5'd15, 1'b1, 1'b1, 32'h00007f80);
        // Loads right behind stores to the same word
        add_row(M_ST_W,  32'h00000300, 32'hcafef00d, 5'd0,  1'b0, 1'b0, 32'h00000000);
        add_row(M_LD_W,  32'h00000300, 32'h00000000, 5'd16, 1'b1, 1'b1, 32'hcafef00d);
        add_row(M_ST_B,  32'h00000303, 32'h0000005a, 5'd0,  1'b0, 1'b0, 32'h00000000);
        add_row(M_LD_BU, 32'h00000303, 32'h00000000, 5'd17, 1'b1, 1'b1, 32'h0000005a);
        add_row(M_ALU,   32'h0badf00d, 32'h00000000, 5'd18, 1'b1, 1'b0, 32'h0badf00d);
        add_row(M_ALU,   32'h13579bdf, 32'h00000000, 5'd31, 1'b1, 1'b0, 32'h13579bdf);
    endtask

    task automatic drive_row(input int idx);
        ex_valid        = 1'b1;
        ex_pc           = pc_for_row(idx);
        ex_result       = rows[idx].result;
        ex_rkd_value    = rows[idx].rkd_value;
        ex_mem_op       = rows[idx].op;
        ex_res_from_mem = rows[idx].res_from_mem;
        ex_gr_we        = rows[idx].gr_we;
        ex_mem_we       = rows[idx].op[OP_ST_B] | rows[idx].op[OP_ST_H] | rows[idx].op[OP_ST_W];
        ex_dest         = rows[idx].dest;
    endtask

    // Random writeback stalls redrawn every cycle
    initial begin
        word_t draw;
        forever begin
            @(posedge clk);
            #2;
            draw = $urandom();
            wb_ready = draw[0];
        end
    end

    // Every retirement is matched against the next table row, in order
    always @(negedge clk) begin
        if (!rst && wb_valid && wb_ready) begin
            if (wb_ptr >= rows.size()) begin
                $display("An instruction retired after the last row of the table");
                abort_run();
            end else begin
                check_word("wb_pc", pc_for_row(wb_ptr), wb_pc);
                check_bit("rf_we", rows[wb_ptr].gr_we, rf_we);
                if (rows[wb_ptr].gr_we) begin
                    check_reg_idx("rf_waddr", rows[wb_ptr].dest, rf_waddr);
                    check_word("rf_wdata", rows[wb_ptr].exp_wdata, rf_wdata);
                end
                wb_ptr++;
            end
        end else begin
            check_bit("rf_we", 1'b0, rf_we);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d rows retired",
                     cycle_count, wb_ptr, rows.size());
            abort_run();
        end
    end

    initial begin
        logic accepted;
        rst             = 1'b1;
        ex_valid        = 1'b0;
        ex_pc           = '0;
        ex_result       = '0;
        ex_rkd_value    = '0;
        ex_mem_op       = '0;
        ex_res_from_mem = 1'b0;
        ex_gr_we        = 1'b0;
        ex_mem_we       = 1'b0;
        ex_dest         = '0;
        void'($urandom(91895));
        build_table();
        timeout_limit = 4 * rows.size() * STALL_FREE_LATENCY + 50;

        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // Idle pipeline after reset
        repeat (3) begin
            @(negedge clk);
            check_bit("wb_valid", 1'b0, wb_valid);
            check_bit("ex_ready", 1'b1, ex_ready);
            check_word("wb_pc", `LSU_RESET_PC, wb_pc);
        end
        @(posedge clk);
        #2;

        for (int idx = 0; idx < rows.size(); idx++) begin
            drive_row(idx);
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = ex_ready;
                @(posedge clk);
                #2;
            end
        end
        ex_valid = 1'b0;

        while (wb_ptr < rows.size()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        if (wb_ptr == rows.size()) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("Retired %0d rows, expected %0d", wb_ptr, rows.size());
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  logic              wb_valid,
    input  logic              wb_ready,
    input  lsu_pkg::word_t    pc,
    input  lsu_pkg::word_t    result,
    input  lsu_pkg::mem_op_t  mem_op,
    input  logic              res_from_mem,
    input  logic              gr_we,
    input  lsu_pkg::reg_idx_t dest,
    input  lsu_pkg::word_t    dmem_rdata,
    output logic              rf_we,
    output lsu_pkg::reg_idx_t rf_waddr,
    output lsu_pkg::word_t    rf_wdata,
    output lsu_pkg::word_t    wb_pc
);

    import lsu_pkg::*;

    logic [7:0]  load_byte;
    logic [15:0] load_half;
    word_t       load_value;

    // Lane select from the low address bits
    always_comb begin
        case (result[1:0])
            2'd0:    load_byte = dmem_rdata[7:0];
            2'd1:    load_byte = dmem_rdata[15:8];
            2'd2:    load_byte = dmem_rdata[23:16];
            default: load_byte = dmem_rdata[31:24];
        endcase
    end

    assign load_half = result[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

    always_comb begin
        if (mem_op[OP_LD_B]) begin
            load_value = {{24{load_byte[7]}}, load_byte};
        end else if (mem_op[OP_LD_BU]) begin
            load_value = {24'b0, load_byte};
        end else if (mem_op[OP_LD_H]) begin
            load_value = {{16{load_half[15]}}, load_half};
        end else if (mem_op[OP_LD_HU]) begin
            load_value = {16'b0, load_half};
        end else begin
            // LD_W and anything else take the whole word
            load_value = dmem_rdata;
        end
    end

    // Write only on the retiring cycle so a stall cannot repeat it
    assign rf_we    = wb_valid & gr_we & wb_ready;
    assign rf_waddr = dest;
    assign rf_wdata = res_from_mem ? load_value : result;
    assign wb_pc    = pc;

endmodule

`default_nettype wire
